// File: mdll_pkg.sv
package mdll_pkg;

    // ------------------------------------------------------------
    // control bus widths
    // ------------------------------------------------------------
    localparam int N_DAC_TI   = 5;  // voltage code bits
    localparam int N_DAC_GAIN = 4;  // gain switches, one cold
    localparam int N_DAC_BW   = 3;  // decap legs
    localparam int N_FRAC     = 8;  // filter accumulator fraction

    // ------------------------------------------------------------
    // types
    // ------------------------------------------------------------
    typedef logic [N_DAC_TI-1:0]    dac_code_t;  // binary code
    typedef logic [2**N_DAC_TI-1:0] dac_sel_t;   // one-cold vref select
    typedef logic [2:0]             gain_sel_t;  // 0 = unity, 1..4 switch on
    typedef logic [N_DAC_GAIN-1:0]  gain_oc_t;
    typedef logic [1:0]             bw_sel_t;    // legs enabled
    typedef logic [N_DAC_BW-1:0]    bw_thm_t;
    typedef logic [15:0]            dac_volt_t;  // voltage units

    // ------------------------------------------------------------
    // calibration defaults
    // ------------------------------------------------------------
    localparam dac_volt_t DEF_V_OFFSET  = 16'd1024;  // ladder bottom tap
    localparam dac_volt_t DEF_LSB0      = 16'd4;     // step per code at K = 1
    localparam dac_volt_t DEF_V_GS_DROP = 16'd256;   // follower vgs

endpackage

// File: mdll_dac_ctl_decoder.sv
`timescale 1ns/1ps

module mdll_dac_ctl_decoder import mdll_pkg::*; (
    input  logic      iir_clk,
    input  logic      rst_n,
    input  logic      cfg_valid,         // one-cycle strobe without back-pressure
    input  dac_code_t cfg_code,
    input  gain_sel_t cfg_gain,
    input  bw_sel_t   cfg_bw,
    output dac_sel_t  dinb_sel,          // only bit cfg_code low
    output gain_oc_t  ctlb_dac_gain_oc,  // at most one switch low
    output bw_thm_t   ctl_dac_bw_thm     // low cfg_bw bits set
);

    // reset word is code 0 with gain 0 and bw 0
    localparam dac_sel_t SEL_RST  = ~dac_sel_t'(1);
    localparam gain_oc_t GAIN_RST = '1;
    localparam bw_thm_t  BW_RST   = '0;

    dac_sel_t sel_enc;
    gain_oc_t gain_enc;
    bw_thm_t  bw_enc;

    // ------------------------------------------------------------
    // encoders on the incoming word
    // ------------------------------------------------------------

    // code to one cold
    always_comb begin
        sel_enc = '1;
        sel_enc[cfg_code] = 1'b0;  // tap select is active low
    end

    // gain to one cold
    always_comb begin
        gain_enc = '1;  // all switches off so K = 1
        if (cfg_gain != '0 && cfg_gain <= gain_sel_t'(N_DAC_GAIN)) begin
            gain_enc[2'(cfg_gain - 3'd1)] = 1'b0;  // switch g-1 on
        end
        // 5..7 fall through as unity
    end

    // bw to thermometer saturating at N_DAC_BW legs
    always_comb begin
        bw_enc = '0;
        for (int i = 0; i < N_DAC_BW; i++) begin
            if (i < int'(cfg_bw)) begin
                bw_enc[i] = 1'b1;
            end
        end
    end

    // ------------------------------------------------------------
    // control registers
    // ------------------------------------------------------------

    // switch controls straight from flops so the buses never glitch
    always_ff @(posedge iir_clk) begin
        if (!rst_n) begin
            dinb_sel         <= SEL_RST;
            ctlb_dac_gain_oc <= GAIN_RST;
            ctl_dac_bw_thm   <= BW_RST;
        end else if (cfg_valid) begin  // later strobe overwrites
            dinb_sel         <= sel_enc;
            ctlb_dac_gain_oc <= gain_enc;
            ctl_dac_bw_thm   <= bw_enc;
        end
    end

endmodule

// File: mdll_supply_dac_filter.sv
`timescale 1ns/1ps

module mdll_supply_dac_filter import mdll_pkg::*; #(
    parameter dac_volt_t V_OFFSET = DEF_V_OFFSET  // node level out of reset
) (
    input  logic      iir_clk,
    input  logic      rst_n,
    input  bw_thm_t   ctl_dac_bw_thm,  // more legs, slower node
    input  dac_volt_t vin,             // target level
    output dac_volt_t vout,            // integer part of acc
    output logic      settled          // acc sits on target
);

    localparam int ACC_W = $bits(dac_volt_t) + N_FRAC;

    typedef logic [ACC_W-1:0]        acc_t;
    typedef logic signed [ACC_W:0]   dif_t;  // one extra bit for sign

    acc_t       acc;
    acc_t       acc_nxt;
    acc_t       tgt;      // scaled target
    dif_t       diff;
    dif_t       step;
    logic [2:0] shift;    // 1..4

    // ------------------------------------------------------------
    // time constant
    // ------------------------------------------------------------

    // s = 1 + legs on
    always_comb begin
        shift = 3'd1;
        for (int i = 0; i < N_DAC_BW; i++) begin
            if (ctl_dac_bw_thm[i]) begin
                shift = shift + 3'd1;
            end
        end
    end

    // ------------------------------------------------------------
    // iir step
    // ------------------------------------------------------------
    assign tgt  = {vin, {N_FRAC{1'b0}}};
    assign diff = $signed({1'b0, tgt}) - $signed({1'b0, acc});

    always_comb begin
        step = diff >>> shift;  // floor, never past target
        // tail of the exponential, creep one lsb so we land exactly
        if (step == '0 && diff != '0) begin
            step = diff[ACC_W] ? '1 : dif_t'(1);
        end
        acc_nxt = acc_t'(dif_t'({1'b0, acc}) + step);
    end

    always_ff @(posedge iir_clk) begin
        if (!rst_n) begin
            acc     <= {V_OFFSET, {N_FRAC{1'b0}}};  // node precharged to offset
            settled <= 1'b0;
        end else begin
            acc     <= acc_nxt;
            settled <= (acc_nxt == tgt);  // lines up with acc
        end
    end

    assign vout = acc[N_FRAC +: $bits(dac_volt_t)];  // drop fraction

endmodule

// File: mdll_dcdl_supply_dac.sv
`timescale 1ns/1ps

module mdll_dcdl_supply_dac import mdll_pkg::*; #(
    parameter dac_volt_t V_OFFSET = DEF_V_OFFSET,  // ladder offset
    parameter dac_volt_t LSB0     = DEF_LSB0       // base step
) (
    input  logic      iir_clk,
    input  logic      rst_n,
    input  bw_thm_t   ctl_dac_bw_thm,    // decap legs
    input  gain_oc_t  ctlb_dac_gain_oc,  // gain switches, one cold
    input  dac_sel_t  dinb_sel,          // vref tap, one cold
    output dac_volt_t ana_vref_out,      // filtered dac level
    output logic      settled
);

    gain_oc_t  gain_oh;   // active-high view of gain switches
    dac_code_t code;      // recovered tap index
    logic [2:0] n_on;     // switches closed
    logic [2:0] sw_idx;   // last closed switch
    logic [2:0] k_gain;   // 1..5
    dac_volt_t step;      // LSB0 * K
    dac_volt_t target;    // unfiltered level

    // ------------------------------------------------------------
    // tap recovery
    // ------------------------------------------------------------

    // lowest zero wins, scan top down
    always_comb begin
        code = '0;  // no tap selected -> bottom
        for (int m = 2**N_DAC_TI - 1; m >= 0; m--) begin
            if (!dinb_sel[m]) begin
                code = dac_code_t'(m);
            end
        end
    end

    // ------------------------------------------------------------
    // gain recovery
    // ------------------------------------------------------------
    assign gain_oh = ~ctlb_dac_gain_oc;

    always_comb begin
        n_on   = '0;
        sw_idx = '0;
        for (int j = 0; j < N_DAC_GAIN; j++) begin
            if (gain_oh[j]) begin
                n_on   = n_on + 3'd1;
                sw_idx = 3'(j);
            end
        end
        // switch j shorts the ladder top, K = j + 2
        k_gain = 3'd1;
        if (n_on == 3'd1) begin
            k_gain = sw_idx + 3'd2;
        end
        // none or several closed: unity
    end

    // target = offset + lsb * K * code
    assign step   = LSB0 * dac_volt_t'(k_gain);
    assign target = V_OFFSET + step * dac_volt_t'(code);

    // decap low-pass on the dac node
    mdll_supply_dac_filter #(
        .V_OFFSET (V_OFFSET)
    ) i_mdll_supply_dac_filter (
        .iir_clk        (iir_clk),
        .rst_n          (rst_n),
        .ctl_dac_bw_thm (ctl_dac_bw_thm),
        .vin            (target),
        .vout           (ana_vref_out),
        .settled        (settled)
    );

endmodule

// File: mdll_supply_dac_buffer.sv
`timescale 1ns/1ps

module mdll_supply_dac_buffer import mdll_pkg::*; #(
    parameter dac_volt_t V_GS_DROP = DEF_V_GS_DROP  // follower vgs
) (
    input  logic      iir_clk,
    input  logic      rst_n,
    input  dac_volt_t ana_vref,    // filtered dac node
    input  logic      settled_in,  // from the filter
    output dac_volt_t vout,        // dcdl supply
    output logic      settled      // same stage as vout
);

    dac_volt_t v_sf;  // source node, unregistered

    // ------------------------------------------------------------
    // source follower
    // ------------------------------------------------------------

    // gate below vgs: device off, supply at ground
    always_comb begin
        if (ana_vref > V_GS_DROP) begin
            v_sf = ana_vref - V_GS_DROP;
        end else begin
            v_sf = '0;
        end
    end

    // one stage, settled rides along
    always_ff @(posedge iir_clk) begin
        if (!rst_n) begin
            vout    <= '0;
            settled <= 1'b0;
        end else begin
            vout    <= v_sf;
            settled <= settled_in;
        end
    end

endmodule

// File: mdll_dcdl_supply_dac_top.sv
`timescale 1ns/1ps

module mdll_dcdl_supply_dac_top import mdll_pkg::*; #(
    parameter dac_volt_t V_OFFSET  = DEF_V_OFFSET,   // dac offset
    parameter dac_volt_t LSB0      = DEF_LSB0,       // step per code
    parameter dac_volt_t V_GS_DROP = DEF_V_GS_DROP   // buffer drop
) (
    input  logic      iir_clk,
    input  logic      rst_n,
    input  logic      cfg_valid,  // control word strobe
    input  dac_code_t cfg_code,
    input  gain_sel_t cfg_gain,
    input  bw_sel_t   cfg_bw,
    output dac_volt_t vout,       // dcdl supply
    output logic      settled
);

    // ------------------------------------------------------------
    // control buses and dac node
    // ------------------------------------------------------------
    dac_sel_t  dinb_sel;
    gain_oc_t  ctlb_dac_gain_oc;
    bw_thm_t   ctl_dac_bw_thm;
    dac_volt_t ana_vref_out;
    logic      dac_settled;  // one stage ahead of settled

    mdll_dac_ctl_decoder i_mdll_dac_ctl_decoder (
        .iir_clk          (iir_clk),
        .rst_n            (rst_n),
        .cfg_valid        (cfg_valid),
        .cfg_code         (cfg_code),
        .cfg_gain         (cfg_gain),
        .cfg_bw           (cfg_bw),
        .dinb_sel         (dinb_sel),
        .ctlb_dac_gain_oc (ctlb_dac_gain_oc),
        .ctl_dac_bw_thm   (ctl_dac_bw_thm)
    );

    mdll_dcdl_supply_dac #(
        .V_OFFSET (V_OFFSET),
        .LSB0     (LSB0)
    ) i_mdll_dcdl_supply_dac (
        .iir_clk          (iir_clk),
        .rst_n            (rst_n),
        .ctl_dac_bw_thm   (ctl_dac_bw_thm),
        .ctlb_dac_gain_oc (ctlb_dac_gain_oc),
        .dinb_sel         (dinb_sel),
        .ana_vref_out     (ana_vref_out),
        .settled          (dac_settled)
    );

    // follower onto the dcdl rail
    mdll_supply_dac_buffer #(
        .V_GS_DROP (V_GS_DROP)
    ) i_mdll_supply_dac_buffer (
        .iir_clk    (iir_clk),
        .rst_n      (rst_n),
        .ana_vref   (ana_vref_out),
        .settled_in (dac_settled),
        .vout       (vout),
        .settled    (settled)
    );

endmodule

// File: tb_dac_checker.sv
`timescale 1ns/1ps

module tb_dac_checker import mdll_pkg::*; #(
    parameter dac_volt_t V_OFFSET  = DEF_V_OFFSET,
    parameter dac_volt_t LSB0      = DEF_LSB0,
    parameter dac_volt_t V_GS_DROP = DEF_V_GS_DROP
) (
    input  logic      iir_clk,
    input  logic      rst_n,
    input  logic      cfg_valid,   // strobe as the dut sees it
    input  dac_code_t cfg_code,
    input  gain_sel_t cfg_gain,
    input  dac_volt_t vout,        // dut rail
    input  logic      settled,
    input  logic      check_req,   // end of a test
    input  int        test_id,
    output int        n_tests,
    output int        n_errors
);

    dac_code_t word_code;  // last strobed word
    gain_sel_t word_gain;
    dac_volt_t exp_vout;

    // expected rail straight from the word
    function automatic dac_volt_t ref_vout(input dac_code_t code, input gain_sel_t gain);
        int k;
        int level;
        k = 1;  // gain 0 and 5..7 are unity
        if (gain >= 3'd1 && gain <= 3'd4) begin
            k = int'(gain) + 1;
        end
        level = int'(V_OFFSET) + int'(LSB0) * k * int'(code);
        if (level > int'(V_GS_DROP)) begin
            return dac_volt_t'(level - int'(V_GS_DROP));
        end
        return '0;  // follower cut off
    endfunction

    // ------------------------------------------------------------
    // word tracking
    // ------------------------------------------------------------
    always @(posedge iir_clk) begin
        if (!rst_n) begin
            word_code <= '0;  // decoder reset word
            word_gain <= '0;
        end else if (cfg_valid) begin
            word_code <= cfg_code;
            word_gain <= cfg_gain;
        end
    end

    assign exp_vout = ref_vout(word_code, word_gain);

    // ------------------------------------------------------------
    // compare at the end of each test
    // ------------------------------------------------------------
    always @(posedge iir_clk) begin
        if (!rst_n) begin
            n_tests  <= 0;
            n_errors <= 0;
        end else if (check_req) begin
            n_tests <= n_tests + 1;
            if (!settled) begin
                $display("test %0d failed because settled is low at the end", test_id);
                n_errors <= n_errors + 1;
            end else if (vout !== exp_vout) begin
                $display("error vout expected 0x%h got 0x%h in test %0d",
                         exp_vout, vout, test_id);
                n_errors <= n_errors + 1;
            end else begin
                $display("test %0d ok with vout 0x%h", test_id, vout);
            end
        end
    end

endmodule

// File: tb_mdll_dcdl_supply_dac.sv
`timescale 1ns/1ps

module tb_mdll_dcdl_supply_dac import mdll_pkg::*; ();

    localparam dac_volt_t V_OFFSET  = DEF_V_OFFSET;
    localparam dac_volt_t LSB0      = DEF_LSB0;
    localparam dac_volt_t V_GS_DROP = DEF_V_GS_DROP;
    localparam int N_TESTS = 36;                 // 1 + 3 + 7 + 4 + 1 + 20
    localparam int MAX_CYC = N_TESTS * 300 + 100;

    logic      iir_clk;
    logic      rst_n;
    logic      cfg_valid;
    dac_code_t cfg_code;
    gain_sel_t cfg_gain;
    bw_sel_t   cfg_bw;
    dac_volt_t vout;
    logic      settled;
    logic      check_req;  // tells the checker a test is done
    int        test_id;
    int        n_tests;
    int        n_errors;
    int        n_fail;     // testbench side failures
    int        cycles;

    mdll_dcdl_supply_dac_top #(
        .V_OFFSET  (V_OFFSET),
        .LSB0      (LSB0),
        .V_GS_DROP (V_GS_DROP)
    ) i_mdll_dcdl_supply_dac_top (
        .iir_clk   (iir_clk),
        .rst_n     (rst_n),
        .cfg_valid (cfg_valid),
        .cfg_code  (cfg_code),
        .cfg_gain  (cfg_gain),
        .cfg_bw    (cfg_bw),
        .vout      (vout),
        .settled   (settled)
    );

    tb_dac_checker #(
        .V_OFFSET  (V_OFFSET),
        .LSB0      (LSB0),
        .V_GS_DROP (V_GS_DROP)
    ) i_tb_dac_checker (
        .iir_clk   (iir_clk),
        .rst_n     (rst_n),
        .cfg_valid (cfg_valid),
        .cfg_code  (cfg_code),
        .cfg_gain  (cfg_gain),
        .vout      (vout),
        .settled   (settled),
        .check_req (check_req),
        .test_id   (test_id),
        .n_tests   (n_tests),
        .n_errors  (n_errors)
    );

    // ------------------------------------------------------------
    // clock and run limit
    // ------------------------------------------------------------
    initial iir_clk = 1'b0;
    always #20 iir_clk = ~iir_clk;  // 40 ns period

    always @(posedge iir_clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYC) begin
            $display("timeout after %0d cycles while test %0d was running", cycles, test_id);
            $display("Test failed");
            $finish;
        end
    end

    // one-cycle strobe of a control word
    task automatic send_word(input dac_code_t code, input gain_sel_t gain, input bw_sel_t bw);
        @(posedge iir_clk);
        cfg_valid <= 1'b1;
        cfg_code  <= code;
        cfg_gain  <= gain;
        cfg_bw    <= bw;
        @(posedge iir_clk);
        cfg_valid <= 1'b0;
    endtask

    task automatic await_high;
        while (!settled) begin
            @(negedge iir_clk);  // poll once per cycle
        end
    endtask

    task automatic pulse_check;
        @(posedge iir_clk);
        check_req <= 1'b1;
        @(posedge iir_clk);
        check_req <= 1'b0;
    endtask

    // settled drops within three edges of the strobe if the target moves
    task automatic wait_result(input bit must_drop);
        bit dropped;
        dropped = 1'b0;
        for (int i = 0; i < 4 && !dropped; i++) begin
            @(negedge iir_clk);
            dropped = !settled;
        end
        if (must_drop && !dropped) begin
            $display("test %0d failed because settled never went low", test_id);
            n_fail++;
        end
        if (dropped) begin
            await_high();
        end
        pulse_check();
    endtask

    task automatic run_test(input dac_code_t code, input gain_sel_t gain, input bw_sel_t bw,
                            input bit must_drop);
        test_id <= test_id + 1;
        send_word(code, gain, bw);
        wait_result(must_drop);
    endtask

    // ------------------------------------------------------------
    // stimulus
    // ------------------------------------------------------------
    initial begin
        void'($urandom(45));
        rst_n     = 1'b0;
        cfg_valid = 1'b0;
        cfg_code  = '0;
        cfg_gain  = '0;
        cfg_bw    = '0;
        check_req = 1'b0;
        test_id   = 0;
        n_fail    = 0;
        repeat (3) @(posedge iir_clk);
        rst_n <= 1'b1;

        test_id <= 1;  // offset minus drop out of reset
        await_high();
        pulse_check();

        run_test(5'd0, 3'd0, 2'd0, 1'b0);   // same as reset word
        run_test(5'd31, 3'd0, 2'd1, 1'b1);  // full scale
        run_test(5'd16, 3'd0, 2'd2, 1'b1);  // mid scale

        // gain 1..4 scale and 5..7 act as unity
        for (int g = 1; g < 8; g++) begin
            run_test(5'd10, gain_sel_t'(g), 2'd1, 1'b0);
        end

        // same step on the fastest and slowest node
        run_test(5'd0, 3'd0, 2'd0, 1'b1);
        run_test(5'd20, 3'd0, 2'd0, 1'b1);
        run_test(5'd0, 3'd0, 2'd3, 1'b1);
        run_test(5'd20, 3'd0, 2'd3, 1'b1);

        // retarget in flight
        send_word(5'd31, 3'd4, 2'd3);
        repeat (6) @(posedge iir_clk);
        @(negedge iir_clk);
        if (settled) begin
            $display("settled came back before the second word of the retarget test");
            n_fail++;
        end
        run_test(5'd5, 3'd2, 2'd3, 1'b1);

        for (int r = 0; r < 20; r++) begin
            run_test(dac_code_t'($urandom), gain_sel_t'($urandom), bw_sel_t'($urandom), 1'b0);
        end

        repeat (3) @(posedge iir_clk);
        $display("tests %0d of %0d, checker errors %0d, testbench failures %0d",
                 n_tests, N_TESTS, n_errors, n_fail);
        if (n_errors == 0 && n_fail == 0 && n_tests == N_TESTS) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// File: src.f
mdll_pkg.sv
mdll_dac_ctl_decoder.sv
mdll_supply_dac_filter.sv
mdll_dcdl_supply_dac.sv
mdll_supply_dac_buffer.sv
mdll_dcdl_supply_dac_top.sv
tb_dac_checker.sv
tb_mdll_dcdl_supply_dac.sv

// File: Makefile
# verilator flow for the dcdl supply dac testbench

VERILATOR ?= verilator
TOP       ?= tb_mdll_dcdl_supply_dac
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing
FAIL_MSG  := Test failed

SOURCES := $(shell cat $(FILELIST))
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list these targets"
	@echo "  test   build with verilator, run and search $(LOG) for the fail message"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

test: $(SIM_BIN)
	-./$(SIM_BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation failed, see $(LOG)"; exit 1; fi
	@if ! grep -q "Test passed" $(LOG); then echo "no result in $(LOG)"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
